/* compile.f */
+incdir+tests
source/lsu_pkg.sv
source/decode_lsu.sv
source/byte_bank.sv
source/load_merge.sv
source/data_mem_top.sv
tests/tb_data_mem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb_data_mem

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_data_mem -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# a run without the fail message counts as a pass
if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

exit 0

/* tests/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic fill_vectors();
	// op, size, byte address, store data, expected load value
	// data unused by loads and expected unused by plain stores
	add_vec(OP_ST,   LSU_B,  32'h0000_0010, 32'h0000_0085, 32'h0000_0000);
	add_vec(OP_ST,   LSU_B,  32'h0000_0011, 32'h0000_007a, 32'h0000_0000);
	add_vec(OP_LD,   LSU_B,  32'h0000_0010, 32'h0000_0000, 32'hffff_ff85);
	add_vec(OP_LD,   LSU_BU, 32'h0000_0010, 32'h0000_0000, 32'h0000_0085);
	add_vec(OP_LD,   LSU_B,  32'h0000_0011, 32'h0000_0000, 32'h0000_007a);
	add_vec(OP_LD,   LSU_BU, 32'h0000_0011, 32'h0000_0000, 32'h0000_007a);
	add_vec(OP_ST,   LSU_B,  32'h0000_0013, 32'h1234_56c3, 32'h0000_0000);
	add_vec(OP_LD,   LSU_B,  32'h0000_0013, 32'h0000_0000, 32'hffff_ffc3);
	add_vec(OP_LD,   LSU_BU, 32'h0000_0013, 32'h0000_0000, 32'h0000_00c3);
	// halfwords where 0x25 spans both banks
	add_vec(OP_ST,   LSU_H,  32'h0000_0020, 32'hdead_9abc, 32'h0000_0000);
	add_vec(OP_LD,   LSU_H,  32'h0000_0020, 32'h0000_0000, 32'hffff_9abc);
	add_vec(OP_LD,   LSU_HU, 32'h0000_0020, 32'h0000_0000, 32'h0000_9abc);
	add_vec(OP_ST,   LSU_H,  32'h0000_0025, 32'h0000_f00d, 32'h0000_0000);
	add_vec(OP_LD,   LSU_H,  32'h0000_0025, 32'h0000_0000, 32'hffff_f00d);
	add_vec(OP_LD,   LSU_HU, 32'h0000_0025, 32'h0000_0000, 32'h0000_f00d);
	add_vec(OP_ST,   LSU_H,  32'h0000_002b, 32'h1111_7e55, 32'h0000_0000);
	add_vec(OP_LD,   LSU_H,  32'h0000_002b, 32'h0000_0000, 32'h0000_7e55);
	add_vec(OP_LD,   LSU_HU, 32'h0000_002b, 32'h0000_0000, 32'h0000_7e55);
	// words at offsets 0, 1, 2, 3
	add_vec(OP_ST,   LSU_W,  32'h0000_0100, 32'h8899_aabb, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_0100, 32'h0000_0000, 32'h8899_aabb);
	add_vec(OP_ST,   LSU_W,  32'h0000_0105, 32'h1122_3344, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_0105, 32'h0000_0000, 32'h1122_3344);
	add_vec(OP_ST,   LSU_W,  32'h0000_010a, 32'hcafe_f00d, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_010a, 32'h0000_0000, 32'hcafe_f00d);
	add_vec(OP_ST,   LSU_W,  32'h0000_010f, 32'h7654_3210, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_010f, 32'h0000_0000, 32'h7654_3210);
	add_vec(OP_LD,   LSU_BU, 32'h0000_0105, 32'h0000_0000, 32'h0000_0044);
	add_vec(OP_LD,   LSU_B,  32'h0000_0108, 32'h0000_0000, 32'h0000_0011);
	// partial overwrite and then unsigned store codes
	add_vec(OP_ST,   LSU_B,  32'h0000_0102, 32'h0000_00e7, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_0100, 32'h0000_0000, 32'h88e7_aabb);
	add_vec(OP_ST,   LSU_BU, 32'h0000_010a, 32'hffff_ffff, 32'h0000_0000);
	add_vec(OP_ST,   LSU_HU, 32'h0000_010b, 32'hffff_ffff, 32'h0000_0000);
	add_vec(OP_LD,   LSU_W,  32'h0000_010a, 32'h0000_0000, 32'hcafe_f00d);
	// wrap past the top of the 2 KiB space
	add_vec(OP_ST,   LSU_W,  32'h0000_07fe, 32'ha1b2_c3d4, 32'h0000_0000);
	add_vec(OP_LD,   LSU_B,  32'h0000_0000, 32'h0000_0000, 32'hffff_ffb2);
	add_vec(OP_LD,   LSU_B,  32'h0000_0001, 32'h0000_0000, 32'hffff_ffa1);
	add_vec(OP_LD,   LSU_W,  32'h0000_07fe, 32'h0000_0000, 32'ha1b2_c3d4);
	add_vec(OP_LD,   LSU_HU, 32'h0000_07ff, 32'h0000_0000, 32'h0000_b2c3);
	add_vec(OP_LD,   LSU_W,  32'h0000_47fe, 32'h0000_0000, 32'ha1b2_c3d4);
	// read before write
	add_vec(OP_STLD, LSU_W,  32'h0000_0105, 32'h0bad_f00d, 32'h1122_3344);
	add_vec(OP_LD,   LSU_W,  32'h0000_0105, 32'h0000_0000, 32'h0bad_f00d);
	add_vec(OP_STLD, LSU_B,  32'h0000_0010, 32'h0000_0001, 32'hffff_ff85);
	add_vec(OP_LD,   LSU_B,  32'h0000_0010, 32'h0000_0000, 32'h0000_0001);
endtask

`endif

/* tests/tb_data_mem.sv */
module tb_data_mem import lsu_pkg::*; ();

	localparam int ADDR_W    = 10;
	localparam int MEM_BYTES = 2 << ADDR_W;
	localparam int N_RAND    = 200;
	localparam int N_PREFILL = 18;   // words behind the random window

	localparam int OP_LD   = 0;
	localparam int OP_ST   = 1;
	localparam int OP_STLD = 2;      // store with the old value read back

	logic        i_clk;
	logic        i_rst_n;
	logic [31:0] i_addr;
	lsu_size_t   i_size;
	logic        i_wren;
	logic [31:0] i_st_data;
	logic [31:0] o_ld_data;

	// directed table filled by fill_vectors
	int          vec_op[$];
	lsu_size_t   vec_size[$];
	logic [31:0] vec_addr[$];
	logic [31:0] vec_data[$];
	logic [31:0] vec_exp[$];

	logic [7:0] mdl [0:MEM_BYTES-1];   // reference byte image

	// load applied last cycle and checked on this falling edge
	logic        pend_chk;
	logic [31:0] pend_exp;
	logic [31:0] pend_addr;
	lsu_size_t   pend_size;

	int     err_val;
	int     err_tab;
	int     cycles;
	int     cycle_limit = 0;
	integer seed;

	data_mem_top #(.ADDR_W(ADDR_W)) uut (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_addr    (i_addr),
		.i_size    (i_size),
		.i_wren    (i_wren),
		.i_st_data (i_st_data),
		.o_ld_data (o_ld_data)
	);

	task automatic add_vec(input int op, input lsu_size_t size, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] exp);
		vec_op.push_back(op);
		vec_size.push_back(size);
		vec_addr.push_back(addr);
		vec_data.push_back(data);
		vec_exp.push_back(exp);
	endtask

	`include "tb_vectors.svh"

	// byte k of an access sits at a+k modulo the memory size
	function automatic logic [31:0] expect_load(input logic [31:0] addr, input lsu_size_t size);
		logic [7:0]      b [4];
		logic [ADDR_W:0] a;
		logic [31:0]     v;
		int              k;
		for (k = 0; k < 4; k++) begin
			a    = addr[ADDR_W:0] + k[ADDR_W:0];
			b[k] = mdl[a];
		end
		case (size)
			LSU_B:   v = {{24{b[0][7]}}, b[0]};
			LSU_H:   v = {{16{b[1][7]}}, b[1], b[0]};
			LSU_W:   v = {b[3], b[2], b[1], b[0]};
			LSU_BU:  v = {24'h0, b[0]};
			LSU_HU:  v = {16'h0, b[1], b[0]};
			default: v = 32'h0;
		endcase
		return v;
	endfunction

	task automatic write_model(input logic [31:0] addr, input lsu_size_t size,
		input logic [31:0] data);
		logic [ADDR_W:0] a;
		int              n;
		int              k;
		case (size)
			LSU_B:   n = 1;
			LSU_H:   n = 2;
			LSU_W:   n = 4;
			default: n = 0;   // unsigned codes store nothing
		endcase
		for (k = 0; k < n; k++) begin
			a      = addr[ADDR_W:0] + k[ADDR_W:0];
			mdl[a] = data[8*k +: 8];
		end
	endtask

	task automatic check_load();
		if (pend_chk && (o_ld_data !== pend_exp)) begin
			err_val++;
			$display("Error at %0t: o_ld_data = %h, expected %h (addr %h, size %s)",
				$time, o_ld_data, pend_exp, pend_addr, pend_size.name());
		end
	endtask

	// check the last load, then drive the next access
	task automatic apply_cycle(input logic wren, input lsu_size_t size,
		input logic [31:0] addr, input logic [31:0] data, input logic chk,
		input logic [31:0] exp);
		@(negedge i_clk);
		check_load();
		i_wren    = wren;
		i_size    = size;
		i_addr    = addr;
		i_st_data = data;
		pend_chk  = chk;
		pend_exp  = exp;
		pend_addr = addr;
		pend_size = size;
	endtask

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] a;
		logic [31:0] e;
		lsu_size_t   sz;
		int          i;
		seed      = 32'hcfdb;
		err_val   = 0;
		err_tab   = 0;
		i_rst_n   = 1'b0;
		i_addr    = 32'h0;
		i_size    = LSU_W;
		i_wren    = 1'b0;
		i_st_data = 32'h0;
		pend_chk  = 1'b0;
		pend_exp  = 32'h0;
		pend_addr = 32'h0;
		pend_size = LSU_W;
		fill_vectors();
		cycle_limit = 2*vec_op.size() + N_RAND + 40;
		repeat (16) @(negedge i_clk);
		i_rst_n = 1'b1;

		for (i = 0; i < vec_op.size(); i++) begin
			if (vec_op[i] != OP_ST) begin
				e = expect_load(vec_addr[i], vec_size[i]);
				if (e !== vec_exp[i]) begin
					err_tab++;
					$display("table entry %0d lists %h but the byte model gives %h",
						i, vec_exp[i], e);
				end
			end
			apply_cycle(vec_op[i] != OP_LD, vec_size[i], vec_addr[i], vec_data[i],
				vec_op[i] != OP_ST, vec_exp[i]);
			if (vec_op[i] != OP_LD)
				write_model(vec_addr[i], vec_size[i], vec_data[i]);
		end

		// known contents under the random window
		for (i = 0; i < N_PREFILL; i++) begin
			d = $random(seed);
			a = 32'h400 + 4*i;
			apply_cycle(1'b1, LSU_W, a, d, 1'b0, 32'h0);
			write_model(a, LSU_W, d);
		end

		for (i = 0; i < N_RAND; i++) begin
			r = $random(seed);
			d = $random(seed);
			a = 32'h400 + {26'h0, r[5:0]};
			case (r[10:8])
				3'd0, 3'd5: sz = LSU_B;
				3'd1, 3'd6: sz = LSU_H;
				3'd2, 3'd7: sz = LSU_W;
				3'd3:       sz = LSU_BU;
				default:    sz = LSU_HU;
			endcase
			if (r[16]) begin
				apply_cycle(1'b1, sz, a, d, 1'b0, 32'h0);
				write_model(a, sz, d);
			end else begin
				e = expect_load(a, sz);
				apply_cycle(1'b0, sz, a, 32'h0, 1'b1, e);
			end
		end
		apply_cycle(1'b0, LSU_W, 32'h0, 32'h0, 1'b0, 32'h0); // flush last load

		$display("%0d value errors, %0d table errors", err_val, err_tab);
		if (err_val == 0 && err_tab == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* source/data_mem_top.sv */
module data_mem_top import lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic        i_clk,
	input  logic        i_rst_n,

	input  logic [31:0] i_addr,
	input  lsu_size_t   i_size,
	input  logic        i_wren,
	input  logic [31:0] i_st_data,

	output logic [31:0] o_ld_data
);

	// decoder to bank port wires
	logic [ADDR_W-1:0] addr_even_1;
	logic [ADDR_W-1:0] addr_even_2;
	logic [ADDR_W-1:0] addr_odd_1;
	logic [ADDR_W-1:0] addr_odd_2;

	logic [BYTE_W-1:0] data_even_1;
	logic [BYTE_W-1:0] data_even_2;
	logic [BYTE_W-1:0] data_odd_1;
	logic [BYTE_W-1:0] data_odd_2;

	logic we_even_1;
	logic we_even_2;
	logic we_odd_1;
	logic we_odd_2;

	// bank read bytes
	logic [BYTE_W-1:0] q_even_1;
	logic [BYTE_W-1:0] q_even_2;
	logic [BYTE_W-1:0] q_odd_1;
	logic [BYTE_W-1:0] q_odd_2;

	decode_lsu #(.ADDR_W(ADDR_W)) u_decode (
		.i_addr        (i_addr),
		.i_size        (i_size),
		.i_wren        (i_wren),
		.i_st_data     (i_st_data),
		.o_addr_even_1 (addr_even_1),
		.o_addr_even_2 (addr_even_2),
		.o_addr_odd_1  (addr_odd_1),
		.o_addr_odd_2  (addr_odd_2),
		.o_data_even_1 (data_even_1),
		.o_data_even_2 (data_even_2),
		.o_data_odd_1  (data_odd_1),
		.o_data_odd_2  (data_odd_2),
		.o_we_even_1   (we_even_1),
		.o_we_even_2   (we_even_2),
		.o_we_odd_1    (we_odd_1),
		.o_we_odd_2    (we_odd_2)
	);

	byte_bank #(.ADDR_W(ADDR_W)) u_even ( // even byte addresses
		.i_clk    (i_clk),
		.i_addr_1 (addr_even_1),
		.i_data_1 (data_even_1),
		.i_we_1   (we_even_1),
		.i_addr_2 (addr_even_2),
		.i_data_2 (data_even_2),
		.i_we_2   (we_even_2),
		.o_q_1    (q_even_1),
		.o_q_2    (q_even_2)
	);

	byte_bank #(.ADDR_W(ADDR_W)) u_odd ( // odd byte addresses
		.i_clk    (i_clk),
		.i_addr_1 (addr_odd_1),
		.i_data_1 (data_odd_1),
		.i_we_1   (we_odd_1),
		.i_addr_2 (addr_odd_2),
		.i_data_2 (data_odd_2),
		.i_we_2   (we_odd_2),
		.o_q_1    (q_odd_1),
		.o_q_2    (q_odd_2)
	);

	load_merge #(.ADDR_W(ADDR_W)) u_merge (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_addr_lsb (i_addr[0]),
		.i_size     (i_size),
		.i_q_even_1 (q_even_1),
		.i_q_even_2 (q_even_2),
		.i_q_odd_1  (q_odd_1),
		.i_q_odd_2  (q_odd_2),
		.o_ld_data  (o_ld_data)
	);

endmodule

/* source/load_merge.sv */
module load_merge import lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic               i_clk,
	input  logic               i_rst_n,

	input  logic               i_addr_lsb,
	input  lsu_size_t          i_size,

	input  logic [BYTE_W-1:0]  i_q_even_1,
	input  logic [BYTE_W-1:0]  i_q_even_2,
	input  logic [BYTE_W-1:0]  i_q_odd_1,
	input  logic [BYTE_W-1:0]  i_q_odd_2,

	output logic [31:0]        o_ld_data
);

	localparam int EXT_B = 32 - BYTE_W;
	localparam int EXT_H = 32 - 2*BYTE_W;

	logic      lsb_q;  // parity of the address read last cycle
	lsu_size_t size_q;

	logic [BYTE_W-1:0] b0;
	logic [BYTE_W-1:0] b1;
	logic [BYTE_W-1:0] b2;
	logic [BYTE_W-1:0] b3;

	// control follows the bank read by one cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lsb_q  <= 1'b0;
			size_q <= LSU_W;
		end else begin
			lsb_q  <= i_addr_lsb;
			size_q <= i_size;
		end
	end

	// undo the decoder's routing
	always_comb begin
		if (!lsb_q) begin
			b0 = i_q_even_1;
			b1 = i_q_odd_1;
			b2 = i_q_even_2;
			b3 = i_q_odd_2;
		end else begin
			b0 = i_q_odd_1;
			b1 = i_q_even_1;
			b2 = i_q_odd_2;
			b3 = i_q_even_2;
		end
	end

	always_comb begin
		case (size_q)
			LSU_B:   o_ld_data = {{EXT_B{b0[BYTE_W-1]}}, b0};
			LSU_H:   o_ld_data = {{EXT_H{b1[BYTE_W-1]}}, b1, b0};
			LSU_W:   o_ld_data = {b3, b2, b1, b0};
			LSU_BU:  o_ld_data = {{EXT_B{1'b0}}, b0};
			LSU_HU:  o_ld_data = {{EXT_H{1'b0}}, b1, b0};
			default: o_ld_data = '0;
		endcase
	end

	// four distinct bytes need at least two entries per bank
	initial begin
		assert (ADDR_W >= 1)
			else $fatal(1, "load_merge: ADDR_W %0d too small for word access", ADDR_W);
	end

	a_size_legal: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		size_q inside {LSU_B, LSU_H, LSU_W, LSU_BU, LSU_HU}
	) else $error("load_merge: registered size %b is not a load code", size_q);

endmodule

/* source/byte_bank.sv */
module byte_bank import lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic               i_clk,

	input  logic [ADDR_W-1:0]  i_addr_1,
	input  logic [BYTE_W-1:0]  i_data_1,
	input  logic               i_we_1,

	input  logic [ADDR_W-1:0]  i_addr_2,
	input  logic [BYTE_W-1:0]  i_data_2,
	input  logic               i_we_2,

	output logic [BYTE_W-1:0]  o_q_1,
	output logic [BYTE_W-1:0]  o_q_2
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [BYTE_W-1:0] mem [0:DEPTH-1];

	// each write port on its own enable
	always_ff @(posedge i_clk) begin
		if (i_we_1) begin
			mem[i_addr_1] <= i_data_1;
		end
		if (i_we_2) begin
			mem[i_addr_2] <= i_data_2;
		end
	end

	// registered reads return old contents on a same-edge write
	always_ff @(posedge i_clk) begin
		o_q_1 <= mem[i_addr_1];
		o_q_2 <= mem[i_addr_2];
	end

	// the two ports sit on neighbouring entries and never on the same one
	a_no_dual_write: assert property (
		@(posedge i_clk) !(i_we_1 && i_we_2 && (i_addr_1 == i_addr_2))
	) else $error("byte_bank: both ports write index %0d", i_addr_1);

endmodule

/* source/decode_lsu.sv */
module decode_lsu import lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic [31:0]        i_addr,
	input  lsu_size_t          i_size,
	input  logic               i_wren,
	input  logic [31:0]        i_st_data,

	output logic [ADDR_W-1:0]  o_addr_even_1,
	output logic [ADDR_W-1:0]  o_addr_even_2,
	output logic [ADDR_W-1:0]  o_addr_odd_1,
	output logic [ADDR_W-1:0]  o_addr_odd_2,

	output logic [BYTE_W-1:0]  o_data_even_1,
	output logic [BYTE_W-1:0]  o_data_even_2,
	output logic [BYTE_W-1:0]  o_data_odd_1,
	output logic [BYTE_W-1:0]  o_data_odd_2,

	output logic               o_we_even_1,
	output logic               o_we_even_2,
	output logic               o_we_odd_1,
	output logic               o_we_odd_2
);

	logic [ADDR_W:0]   byte_addr;      // low bits of the byte address
	logic [ADDR_W:0]   byte_addr_p1;
	logic [ADDR_W-1:0] idx_even_1;
	logic [ADDR_W-1:0] idx_odd_1;
	logic [ADDR_W-1:0] idx_even_2;
	logic [ADDR_W-1:0] idx_odd_2;

	// which byte of the access each port carries
	logic [1:0] bnum_even_1;
	logic [1:0] bnum_even_2;
	logic [1:0] bnum_odd_1;
	logic [1:0] bnum_odd_2;

	logic [2:0] n_bytes;           // bytes written by this store

	assign byte_addr    = i_addr[ADDR_W:0];
	assign byte_addr_p1 = byte_addr + 1'b1; // wraps at the memory size

	// first even byte at or above a, first odd byte at or above a
	assign idx_even_1 = byte_addr_p1[ADDR_W:1];
	assign idx_odd_1  = byte_addr[ADDR_W:1];

	// second entry in each bank wraps modulo 2^ADDR_W
	assign idx_even_2 = idx_even_1 + 1'b1;
	assign idx_odd_2  = idx_odd_1 + 1'b1;

	assign o_addr_even_1 = idx_even_1;
	assign o_addr_even_2 = idx_even_2;
	assign o_addr_odd_1  = idx_odd_1;
	assign o_addr_odd_2  = idx_odd_2;

	// even a gives even1=0 odd1=1 even2=2 odd2=3
	// odd a gives odd1=0 even1=1 odd2=2 even2=3
	assign bnum_even_1 = {1'b0, byte_addr[0]};
	assign bnum_odd_1  = {1'b0, ~byte_addr[0]};
	assign bnum_even_2 = {1'b1, byte_addr[0]};
	assign bnum_odd_2  = {1'b1, ~byte_addr[0]};

	always_comb begin
		case (i_size)
			LSU_B:   n_bytes = 3'd1;
			LSU_H:   n_bytes = 3'd2;
			LSU_W:   n_bytes = 3'd4;
			default: n_bytes = 3'd0; // unsigned codes store nothing
		endcase
	end

	function automatic logic [BYTE_W-1:0] pick_byte(
		input logic [31:0] data,
		input logic [1:0]  bnum
	);
		logic [BYTE_W-1:0] b;
		b = data[bnum*BYTE_W +: BYTE_W];
		return b;
	endfunction

	function automatic logic port_we(
		input logic       wren,
		input logic [1:0] bnum,
		input logic [2:0] cnt
	);
		logic we;
		we = wren && ({1'b0, bnum} < cnt);
		return we;
	endfunction

	assign o_data_even_1 = pick_byte(i_st_data, bnum_even_1);
	assign o_data_even_2 = pick_byte(i_st_data, bnum_even_2);
	assign o_data_odd_1  = pick_byte(i_st_data, bnum_odd_1);
	assign o_data_odd_2  = pick_byte(i_st_data, bnum_odd_2);

	assign o_we_even_1 = port_we(i_wren, bnum_even_1, n_bytes);
	assign o_we_even_2 = port_we(i_wren, bnum_even_2, n_bytes);
	assign o_we_odd_1  = port_we(i_wren, bnum_odd_1, n_bytes);
	assign o_we_odd_2  = port_we(i_wren, bnum_odd_2, n_bytes);

	// the four ports carry bytes 0 to 3 once each
	// so the enables count the store size, and none without i_wren
	always_comb begin
		assert ($countones({o_we_even_1, o_we_even_2, o_we_odd_1, o_we_odd_2})
			== (i_wren ? n_bytes : 3'd0))
			else $error("decode_lsu: bank write enables do not match the store size");
	end

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

	// access sizes with the RV32 load/store funct3 codes
	typedef enum logic [2:0] {
		LSU_B  = 3'b000, // sign extended byte
		LSU_H  = 3'b001, // sign extended halfword
		LSU_W  = 3'b010, // word
		LSU_BU = 3'b100, // zero extended byte
		LSU_HU = 3'b101  // zero extended halfword
	} lsu_size_t;

	// width of one bank entry
	localparam int BYTE_W = 8;

	// codes 011, 110 and 111 are unused
	// stores only act on LSU_B, LSU_H and LSU_W

endpackage
